/* bench/opl3_regs_properties.sv */
// host port assertions of the FM register file, bound into the top level
`timescale 1ns/1ps

module opl3_regs_properties (
    input logic       clk,
    input logic       arst_n,
    input logic       cs,
    input logic       rd,
    input logic [7:0] address,
    input logic [7:0] data_out,
    input logic       rd_valid
);

    logic op_addr;
    logic ch_addr;
    logic unmapped;

    assign op_addr  = (address[7:5] inside {3'd1, 3'd2, 3'd3, 3'd4, 3'd7})
                      && (address[2:0] < 3'd6) && (address[4:3] != 2'd3);
    assign ch_addr  = (address[7:4] inside {4'hA, 4'hB, 4'hC}) && (address[3:0] < 4'd9);
    assign unmapped = !op_addr && !ch_addr && (address != 8'h01);  // 0x01 is the id

    read_latency: assert property (@(posedge clk) disable iff (!arst_n)
        cs && rd |-> ##2 rd_valid)
        else $error("rd_valid missing two cycles after a read");

    no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> $past(cs && rd, 2))
        else $error("rd_valid without a read two cycles before");

    valid_in_reset: assert property (@(posedge clk) !arst_n |-> !rd_valid)
        else $error("rd_valid high during reset");

    unmapped_read: assert property (@(posedge clk) disable iff (!arst_n)
        cs && rd && unmapped |-> ##2 data_out == 8'hFF)
        else $error("unmapped read did not return 0xFF");

endmodule

bind opl3_regs_top opl3_regs_properties props_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .cs       (cs),
    .rd       (rd),
    .address  (address),
    .data_out (data_out),
    .rd_valid (rd_valid)
);

/* bench/opl3_regs_tb.sv */
// testbench for the FM register file, table driven with a random sweep at the end
`timescale 1ns/1ps

module opl3_regs_tb;

    typedef struct packed {
        logic [2:0] test;
        logic       is_wr;
        logic       bank;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] exp_val;    // reads only
    } entry_t;

    localparam int NUM_ENTRIES = 35;
    localparam int RD_TIMEOUT  = 10;    // cycles

    logic       clk;
    logic       arst_n;
    logic       cs;
    logic       wr;
    logic       rd;
    logic       bank_select;
    logic [7:0] address;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       rd_valid;

    logic [7:0]  model [2][256] = '{default: '0};
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          test_errs;

    // test, write, bank, address, data, expected read
    entry_t stim [NUM_ENTRIES] = '{
        '{3'd1, 1'b0, 1'b0, 8'h20, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b0, 8'h55, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b0, 8'hA8, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b0, 8'hC0, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b1, 8'h20, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b1, 8'h55, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b1, 8'hA8, 8'h00, 8'h00},
        '{3'd1, 1'b0, 1'b1, 8'hC0, 8'h00, 8'h00},
        '{3'd2, 1'b0, 1'b0, 8'h01, 8'h00, 8'hBA},
        '{3'd2, 1'b0, 1'b1, 8'h01, 8'h00, 8'hBE},
        '{3'd3, 1'b1, 1'b1, 8'h20, 8'h5A, 8'h00},
        '{3'd3, 1'b1, 1'b1, 8'h2D, 8'hC3, 8'h00},
        '{3'd3, 1'b1, 1'b1, 8'h35, 8'h81, 8'h00},
        '{3'd3, 1'b0, 1'b1, 8'h20, 8'h00, 8'h5A},
        '{3'd3, 1'b0, 1'b1, 8'h2D, 8'h00, 8'hC3},
        '{3'd3, 1'b0, 1'b1, 8'h35, 8'h00, 8'h81},
        '{3'd3, 1'b0, 1'b0, 8'h20, 8'h00, 8'h00},
        '{3'd3, 1'b0, 1'b0, 8'h2D, 8'h00, 8'h00},
        '{3'd3, 1'b0, 1'b0, 8'h35, 8'h00, 8'h00},
        '{3'd4, 1'b1, 1'b0, 8'hB3, 8'hFF, 8'h00},
        '{3'd4, 1'b1, 1'b0, 8'hE8, 8'hFF, 8'h00},
        '{3'd4, 1'b0, 1'b0, 8'hB3, 8'h00, 8'h3F},
        '{3'd4, 1'b0, 1'b0, 8'hE8, 8'h00, 8'h07},
        '{3'd5, 1'b0, 1'b0, 8'h26, 8'h00, 8'hFF},
        '{3'd5, 1'b0, 1'b0, 8'h04, 8'h00, 8'hFF},
        '{3'd5, 1'b0, 1'b0, 8'hA9, 8'h00, 8'hFF},
        '{3'd5, 1'b0, 1'b0, 8'hBD, 8'h00, 8'hFF},
        '{3'd5, 1'b1, 1'b0, 8'h26, 8'h77, 8'h00},
        '{3'd5, 1'b1, 1'b0, 8'h04, 8'h77, 8'h00},
        '{3'd5, 1'b1, 1'b0, 8'hA9, 8'h77, 8'h00},
        '{3'd5, 1'b1, 1'b0, 8'hBD, 8'h77, 8'h00},
        '{3'd5, 1'b0, 1'b0, 8'h28, 8'h00, 8'h00},
        '{3'd5, 1'b0, 1'b0, 8'hA4, 8'h00, 8'h00},
        '{3'd5, 1'b0, 1'b0, 8'hB3, 8'h00, 8'h3F},
        '{3'd5, 1'b0, 1'b0, 8'hE8, 8'h00, 8'h07}
    };

    opl3_regs_top dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .cs          (cs),
        .wr          (wr),
        .rd          (rd),
        .bank_select (bank_select),
        .address     (address),
        .data_in     (data_in),
        .data_out    (data_out),
        .rd_valid    (rd_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // operator windows skip columns 6 and 7 of each row of eight
    function automatic bit is_mapped(input logic [7:0] a);
        if (a[7:5] inside {3'd1, 3'd2, 3'd3, 3'd4, 3'd7})
            return (a[2:0] < 3'd6) && (a[4:3] != 2'd3);
        return (a[7:4] inside {4'hA, 4'hB, 4'hC}) && (a[3:0] < 4'd9);
    endfunction

    function automatic logic [7:0] keep_mask(input logic [7:0] a);
        if (a[7:5] == 3'd7)
            return 8'h07;   // waveform select
        if (a[7:4] == 4'hB)
            return 8'h3F;   // kon, block, fnum high
        return 8'hFF;
    endfunction

    function automatic logic [7:0] model_read(input logic b, input logic [7:0] a);
        if (a == 8'h01)
            return b ? 8'hBE : 8'hBA;
        if (is_mapped(a))
            return model[b][a];
        return 8'hFF;
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic host_write(input logic b, input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        cs          <= 1'b1;
        wr          <= 1'b1;
        bank_select <= b;
        address     <= a;
        data_in     <= d;
        @(posedge clk);
        cs <= 1'b0;
        wr <= 1'b0;
        if (is_mapped(a))
            model[b][a] = d & keep_mask(a);
    endtask

    task automatic host_read(input logic b, input logic [7:0] a, input logic [7:0] exp);
        int waited;
        waited = 0;
        @(posedge clk);
        cs          <= 1'b1;
        rd          <= 1'b1;
        bank_select <= b;
        address     <= a;
        @(posedge clk);
        cs <= 1'b0;
        rd <= 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rd_valid && waited < RD_TIMEOUT);
        if (!rd_valid) begin
            $display("timeout: no rd_valid for the read of bank %0d address %h", b, a);
            errors++;
            test_errs++;
        end else begin
            check("data_out", data_out, exp);
        end
    endtask

    task automatic report_test(input int n);
        $display("test %0d done, %0d errors", n, test_errs);
        test_errs = 0;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b1;
        cs          = 1'b0;
        wr          = 1'b0;
        rd          = 1'b0;
        bank_select = 1'b0;
        address     = '0;
        data_in     = '0;
        errors      = 0;
        checks      = 0;
        test_errs   = 0;
        rng         = 32'd52;
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("data_out", data_out, 8'h00);  // cleared by reset

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (i > 0 && stim[i].test != stim[i-1].test)
                report_test(stim[i-1].test);
            if (stim[i].is_wr)
                host_write(stim[i].bank, stim[i].addr, stim[i].data);
            else
                host_read(stim[i].bank, stim[i].addr, stim[i].exp_val);
        end
        report_test(stim[NUM_ENTRIES-1].test);

        // sweep every mapped register of both banks
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 256; a++) begin
                if (is_mapped(8'(a))) begin
                    rng = xorshift32(rng);
                    host_write(b[0], 8'(a), rng[7:0]);
                end
            end
        end
        // read back the whole map, holes and id included
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 256; a++)
                host_read(b[0], 8'(a), model_read(b[0], 8'(a)));
        end
        report_test(6);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/bash
# build and run the register file testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module opl3_regs_tb -o opl3_regs_sim
./obj_dir/opl3_regs_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi

/* src.f */
verilog/opl3_reg_pkg.sv
verilog/opl3_field_pkg.sv
verilog/reg_access_if.sv
verilog/host_decode.sv
verilog/reg_store.sv
verilog/readback.sv
verilog/opl3_regs_top.sv
bench/opl3_regs_properties.sv
bench/opl3_regs_tb.sv

/* verilog/host_decode.sv */
// host decoder, registers each access and maps its address to group and slot
`timescale 1ns/1ps

module host_decode
    import opl3_reg_pkg::*;
    import opl3_field_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cs,
    input  logic  wr,
    input  logic  rd,
    input  logic  bank_select,
    input  addr_t address,
    input  byte_t data_in,
    reg_access_if.decoder acc
);

    logic       access;
    logic [4:0] op_off;     // offset inside the operator window
    logic       op_hit;
    logic       ch_hit;
    logic       op_map;
    logic       ch_map;
    op_group_t  op_grp;
    ch_group_t  ch_grp;
    op_slot_t   slot_n;
    read_kind_t kind_n;
    reg_byte_u  din;
    reg_byte_u  dmask;

    assign access  = cs && (wr || rd);
    assign op_off  = address[4:0];
    assign din.raw = data_in;

    always_comb begin
        op_hit = 1'b1;
        op_grp = OG_CHAR;
        case (address[7:5])
            BASE_CHAR[7:5]:    op_grp = OG_CHAR;
            BASE_LEVEL[7:5]:   op_grp = OG_LEVEL;
            BASE_ATT_DEC[7:5]: op_grp = OG_ATT_DEC;
            BASE_SUS_REL[7:5]: op_grp = OG_SUS_REL;
            BASE_WAVE[7:5]:    op_grp = OG_WAVE;
            default:           op_hit = 1'b0;
        endcase
    end

    always_comb begin
        ch_hit = 1'b1;
        ch_grp = CG_FNUM_LO;
        case (address[7:4])
            BASE_FNUM_LO[7:4]:   ch_grp = CG_FNUM_LO;
            BASE_KON_BLOCK[7:4]: ch_grp = CG_KON_BLOCK;
            BASE_CTRL[7:4]:      ch_grp = CG_CTRL;
            default:             ch_hit = 1'b0;
        endcase
    end

    // gapped layout, columns 6 and 7 of each row are holes
    assign op_map = op_hit && (op_off[2:0] < OP_ROW_LEN) && (op_off[4:3] < OP_ROWS);
    assign ch_map = ch_hit && (address[3:0] < NUM_CHANNELS);
    assign slot_n = op_slot_t'(op_off[4:3] * OP_ROW_LEN + op_off[2:0]);

    always_comb begin
        if (op_map)
            kind_n = RK_OP;
        else if (ch_map)
            kind_n = RK_CH;
        else if (address == ADDR_ID)
            kind_n = RK_ID;
        else
            kind_n = RK_NONE;
    end

    // rebuild the byte through the view of its group so reserved bits drop out
    always_comb begin
        dmask.raw = '0;
        if (op_hit) begin
            case (op_grp)
                OG_CHAR:    dmask.op_char  = din.op_char;
                OG_LEVEL:   dmask.op_level = din.op_level;
                OG_ATT_DEC,
                OG_SUS_REL: dmask.op_rate  = din.op_rate;
                default:    dmask.op_wave  = '{rsvd: '0, ws: din.op_wave.ws};
            endcase
        end else begin
            case (ch_grp)
                CG_KON_BLOCK: dmask.ch_kon = '{rsvd: '0, kon: din.ch_kon.kon,
                                               block: din.ch_kon.block,
                                               fnum_hi: din.ch_kon.fnum_hi};
                CG_CTRL:      dmask.ch_ctrl = din.ch_ctrl;
                default:      dmask.raw = din.raw;  // fnum low byte
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc.wr_en <= 1'b0;
            acc.rd_en <= 1'b0;
        end else begin
            acc.wr_en <= cs && wr && (op_map || ch_map);  // unmapped writes vanish
            acc.rd_en <= cs && rd;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            acc.bank     <= bank_select;
            acc.is_op    <= op_map;
            acc.op_group <= op_grp;
            acc.ch_group <= ch_grp;
            acc.slot     <= slot_n;
            acc.ch_idx   <= address[3:0];
            acc.wdata    <= dmask.raw;
            acc.rd_kind  <= kind_n;
        end
    end

endmodule

/* verilog/opl3_field_pkg.sv */
// bit layouts of the operator and channel register bytes
package opl3_field_pkg;

    typedef struct packed {
        logic       am;     // tremolo
        logic       vib;    // vibrato
        logic       egt;    // sustaining envelope
        logic       ksr;
        logic [3:0] mult;
    } op_char_t;

    typedef struct packed {
        logic [1:0] ksl;
        logic [5:0] tl;     // total level
    } op_level_t;

    // attack/decay or sustain/release
    typedef struct packed {
        logic [3:0] rate_hi;
        logic [3:0] rate_lo;
    } op_rate_t;

    typedef struct packed {
        logic [4:0] rsvd;
        logic [2:0] ws;
    } op_wave_t;

    typedef struct packed {
        logic [1:0] rsvd;
        logic       kon;
        logic [2:0] block;
        logic [1:0] fnum_hi;  // fnum bits 9:8
    } ch_kon_t;

    typedef struct packed {
        logic       chd;
        logic       chc;
        logic       chb;
        logic       cha;
        logic [2:0] fb;     // feedback
        logic       cnt;
    } ch_ctrl_t;

    typedef union packed {
        logic [7:0] raw;
        op_char_t   op_char;
        op_level_t  op_level;
        op_rate_t   op_rate;
        op_wave_t   op_wave;
        ch_kon_t    ch_kon;
        ch_ctrl_t   ch_ctrl;
    } reg_byte_u;

endpackage

/* verilog/opl3_reg_pkg.sv */
// register map of the two-bank FM register file: addresses, counts and read kinds
package opl3_reg_pkg;

    typedef logic [7:0] addr_t;
    typedef logic [7:0] byte_t;

    localparam int NUM_OP_SLOTS  = 18;  // per bank
    localparam int NUM_CHANNELS  = 9;   // per bank
    localparam int NUM_OP_GROUPS = 5;
    localparam int NUM_CH_GROUPS = 3;

    // operator window is three rows of eight addresses, six used per row
    localparam int OP_ROW_LEN = 6;
    localparam int OP_ROWS    = 3;

    localparam addr_t BASE_CHAR      = 8'h20;
    localparam addr_t BASE_LEVEL     = 8'h40;
    localparam addr_t BASE_ATT_DEC   = 8'h60;
    localparam addr_t BASE_SUS_REL   = 8'h80;
    localparam addr_t BASE_WAVE      = 8'hE0;
    localparam addr_t BASE_FNUM_LO   = 8'hA0;
    localparam addr_t BASE_KON_BLOCK = 8'hB0;
    localparam addr_t BASE_CTRL      = 8'hC0;

    typedef enum logic [2:0] {OG_CHAR, OG_LEVEL, OG_ATT_DEC, OG_SUS_REL, OG_WAVE} op_group_t;
    typedef enum logic [1:0] {CG_FNUM_LO, CG_KON_BLOCK, CG_CTRL} ch_group_t;

    typedef logic [4:0] op_slot_t;
    typedef logic [3:0] ch_idx_t;

    localparam addr_t ADDR_ID  = 8'h01;
    localparam byte_t ID_BANK0 = 8'hBA;
    localparam byte_t ID_BANK1 = 8'hBE;

    localparam byte_t UNMAPPED_READ = 8'hFF;

    // what the readback stage returns for a read
    typedef enum logic [1:0] {RK_OP, RK_CH, RK_ID, RK_NONE} read_kind_t;

endpackage

/* verilog/opl3_regs_top.sv */
// top level of the FM register file with the byte-wide host port
`timescale 1ns/1ps

module opl3_regs_top
    import opl3_reg_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cs,
    input  logic  wr,
    input  logic  rd,
    input  logic  bank_select,
    input  addr_t address,
    input  byte_t data_in,
    output byte_t data_out,
    output logic  rd_valid
);

    reg_access_if acc ();

    byte_t rdata;

    host_decode u_host_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .cs          (cs),
        .wr          (wr),
        .rd          (rd),
        .bank_select (bank_select),
        .address     (address),
        .data_in     (data_in),
        .acc         (acc.decoder)
    );

    reg_store u_reg_store (
        .clk    (clk),
        .arst_n (arst_n),
        .acc    (acc.store),
        .rdata  (rdata)
    );

    readback u_readback (
        .clk      (clk),
        .arst_n   (arst_n),
        .acc      (acc.reader),
        .rdata    (rdata),
        .data_out (data_out),
        .rd_valid (rd_valid)
    );

endmodule

/* verilog/readback.sv */
// readback stage, registers data_out and pulses rd_valid for each read
`timescale 1ns/1ps

module readback
    import opl3_reg_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    reg_access_if.reader acc,
    input  byte_t rdata,
    output byte_t data_out,
    output logic  rd_valid
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= acc.rd_en;
            if (acc.rd_en) begin
                case (acc.rd_kind)
                    RK_OP,
                    RK_CH:   data_out <= rdata;
                    RK_ID:   data_out <= acc.bank ? ID_BANK1 : ID_BANK0;  // sanity value
                    default: data_out <= UNMAPPED_READ;
                endcase
            end
        end
    end

endmodule

/* verilog/reg_access_if.sv */
// decoded register access from the host decoder to the store and readback
`timescale 1ns/1ps

interface reg_access_if import opl3_reg_pkg::*; ();

    logic       wr_en;
    logic       rd_en;
    logic       bank;
    logic       is_op;      // operator array, else channel array
    op_group_t  op_group;
    ch_group_t  ch_group;
    op_slot_t   slot;
    ch_idx_t    ch_idx;
    byte_t      wdata;      // reserved bits already cleared
    read_kind_t rd_kind;

    modport decoder (output wr_en, rd_en, bank, is_op, op_group, ch_group, slot, ch_idx,
                     wdata, rd_kind);
    modport store   (input wr_en, bank, is_op, op_group, ch_group, slot, ch_idx, wdata);
    modport reader  (input rd_en, bank, rd_kind);

endinterface

/* verilog/reg_store.sv */
// register arrays of both banks with one write port and a combinational read
`timescale 1ns/1ps

module reg_store
    import opl3_reg_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    reg_access_if.store acc,
    output byte_t rdata
);

    // bank x group x slot
    byte_t op_regs [2][NUM_OP_GROUPS][NUM_OP_SLOTS];
    byte_t ch_regs [2][NUM_CH_GROUPS][NUM_CHANNELS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_regs <= '{default: '0};
        end else if (acc.wr_en && acc.is_op) begin
            op_regs[acc.bank][acc.op_group][acc.slot] <= acc.wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ch_regs <= '{default: '0};
        end else if (acc.wr_en && !acc.is_op) begin
            ch_regs[acc.bank][acc.ch_group][acc.ch_idx] <= acc.wdata;
        end
    end

    // old value on a same-cycle write, new one lands at the edge
    always_comb begin
        if (acc.is_op)
            rdata = op_regs[acc.bank][acc.op_group][acc.slot];
        else
            rdata = ch_regs[acc.bank][acc.ch_group][acc.ch_idx];
    end

endmodule
